// ==== adc/adc_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_channel import r24_bus_pkg::*, r24_dsp_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_i,

    // Register port
    input  wire logic      sel_i,
    input  wire logic      penable_i,
    input  wire logic      pwrite_i,
    input  wire offset_t   offset_i,
    input  wire apb_data_t wdata_i,
    output apb_data_t      rdata_o,

    // Converter side
    input  wire sample_t   sample_i,
    input  wire logic      dor_i,     // Data overrange from the ADC
    output sample_t        sample_o,
    output att_t           att_o,
    output logic           amp_en_o
);

    logic    wr_en;
    sample_t sample_q;
    att_t    att_q;
    logic    amp_en_q;
    logic    ovr_q;      // Sticky overrange

    // Access phase write strobe
    assign wr_en = sel_i && penable_i && pwrite_i;

    //////////////////////////////////////////////////////////////////////
    // Sample path and registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sample_q <= '0;
            att_q    <= '0;
            amp_en_q <= 1'b0;
            ovr_q    <= 1'b0;
        end else begin
            sample_q <= sample_i;  // Free running, one cycle
            if (wr_en && offset_i == REG_CTRL) begin
                att_q    <= att_t'(wdata_i[1:0]);
                amp_en_q <= wdata_i[CTRL_AMP_BIT];
            end
            // Set has priority over write-1-to-clear
            if (dor_i)
                ovr_q <= 1'b1;
            else if (wr_en && offset_i == REG_STATUS && wdata_i[0])
                ovr_q <= 1'b0;
        end
    end

    assign sample_o = sample_q;
    assign att_o    = att_q;
    assign amp_en_o = amp_en_q;

    // Read data, zero for unused offsets
    always_comb begin
        rdata_o = '0;
        case (offset_i)
            REG_CTRL: begin
                rdata_o[1:0]          = att_q;
                rdata_o[CTRL_AMP_BIT] = amp_en_q;
            end
            REG_STATUS: rdata_o[0] = ovr_q;
            REG_SAMPLE: rdata_o = {{(DATA_W-SAMPLE_W){sample_q[SAMPLE_W-1]}}, sample_q};
            default:    rdata_o = '0;
        endcase
    end

    // Flag must be up one cycle after any overrange
    ovr_sticky: assert property (@(posedge clk) disable iff (rst_i)
        dor_i |=> ovr_q);

endmodule

`default_nettype wire

// ==== common/r24_bus_pkg.sv ====
`default_nettype none

package r24_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // APB widths
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W   = 16;
    localparam int DATA_W   = 32;
    localparam int OFFSET_W = 12;  // Register offset inside one region

    typedef logic [ADDR_W-1:0]          apb_addr_t;
    typedef logic [DATA_W-1:0]          apb_data_t;
    typedef logic [ADDR_W-OFFSET_W-1:0] region_t;   // paddr[15:12]
    typedef logic [OFFSET_W-1:0]        offset_t;   // paddr[11:0]

    // Region map, 4 and 7 left unmapped
    localparam region_t REGION_INA  = 4'd0;
    localparam region_t REGION_INB  = 4'd1;
    localparam region_t REGION_OUTA = 4'd2;
    localparam region_t REGION_OUTB = 4'd3;
    localparam region_t REGION_DDSA = 4'd5;
    localparam region_t REGION_DDSB = 4'd6;

    //////////////////////////////////////////////////////////////////////
    // Register offsets
    //////////////////////////////////////////////////////////////////////

    localparam offset_t REG_CTRL      = 12'h000;  // att[1:0], amp_en[2]
    localparam offset_t REG_STATUS    = 12'h004;  // ADC only
    localparam offset_t REG_SRC       = 12'h004;  // DAC only
    localparam offset_t REG_SAMPLE    = 12'h008;  // ADC only
    localparam offset_t REG_CONST     = 12'h008;  // DAC only
    localparam offset_t REG_PHASE_INC = 12'h000;  // DDS
    localparam offset_t REG_PHASE     = 12'h004;  // DDS

    localparam int CTRL_AMP_BIT = 2;  // Amplifier enable in CTRL

endpackage

`default_nettype wire

// ==== common/r24_dsp_pkg.sv ====
`default_nettype none

package r24_dsp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sample and phase types
    //////////////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 8;   // Converter width, both ADC and DAC
    localparam int PHASE_W  = 32;

    // Lowest phase bit that reaches the output
    localparam int PHASE_MSB_LO = PHASE_W - SAMPLE_W;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [PHASE_W-1:0]         phase_t;

    // Front-end attenuator step
    typedef logic [1:0] att_t;

    //////////////////////////////////////////////////////////////////////
    // DAC source select
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        SRC_INA   = 3'd0,  // ADC channel A
        SRC_INB   = 3'd1,  // ADC channel B
        SRC_DDSA  = 3'd2,
        SRC_DDSB  = 3'd3,
        SRC_CONST = 3'd4   // Constant register, highest legal code
    } dac_src_t;

endpackage

`default_nettype wire

// ==== dac/dac_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module dac_channel import r24_bus_pkg::*, r24_dsp_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_i,

    // Register port
    input  wire logic      sel_i,
    input  wire logic      penable_i,
    input  wire logic      pwrite_i,
    input  wire offset_t   offset_i,
    input  wire apb_data_t wdata_i,
    output apb_data_t      rdata_o,

    // Candidate sources
    input  wire sample_t   ina_i,
    input  wire sample_t   inb_i,
    input  wire sample_t   ddsa_i,
    input  wire sample_t   ddsb_i,

    output sample_t        dac_o,
    output att_t           att_o,
    output logic           amp_en_o
);

    logic     wr_en;
    att_t     att_q;
    logic     amp_en_q;
    dac_src_t src_q;
    sample_t  const_q;
    sample_t  src_data;   // Selected source, before the output flop
    sample_t  dac_q;

    assign wr_en = sel_i && penable_i && pwrite_i;

    //////////////////////////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            att_q    <= '0;
            amp_en_q <= 1'b0;
            src_q    <= SRC_INA;
            const_q  <= '0;
        end else if (wr_en) begin
            case (offset_i)
                REG_CTRL: begin
                    att_q    <= att_t'(wdata_i[1:0]);
                    amp_en_q <= wdata_i[CTRL_AMP_BIT];
                end
                REG_SRC: begin
                    // Out of range codes leave the source unchanged
                    if (wdata_i <= apb_data_t'(SRC_CONST))
                        src_q <= dac_src_t'(wdata_i[2:0]);
                end
                REG_CONST: const_q <= sample_t'(wdata_i[SAMPLE_W-1:0]);
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Source mux and output register
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (src_q)
            SRC_INA:  src_data = ina_i;
            SRC_INB:  src_data = inb_i;
            SRC_DDSA: src_data = ddsa_i;
            SRC_DDSB: src_data = ddsb_i;
            default:  src_data = const_q;  // SRC_CONST
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i)
            dac_q <= '0;
        else
            dac_q <= src_data;  // Reloaded every cycle
    end

    assign dac_o    = dac_q;
    assign att_o    = att_q;
    assign amp_en_o = amp_en_q;

    always_comb begin
        rdata_o = '0;
        case (offset_i)
            REG_CTRL: begin
                rdata_o[1:0]          = att_q;
                rdata_o[CTRL_AMP_BIT] = amp_en_q;
            end
            REG_SRC:   rdata_o[2:0]          = src_q;
            REG_CONST: rdata_o[SAMPLE_W-1:0] = const_q;  // Zero extended
            default:   rdata_o = '0;
        endcase
    end

    src_legal: assert property (@(posedge clk) disable iff (rst_i)
        src_q <= SRC_CONST);

endmodule

`default_nettype wire

// ==== dds/dds_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module dds_block import r24_bus_pkg::*, r24_dsp_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_i,

    // Register port
    input  wire logic      sel_i,
    input  wire logic      penable_i,
    input  wire logic      pwrite_i,
    input  wire offset_t   offset_i,
    input  wire apb_data_t wdata_i,
    output apb_data_t      rdata_o,

    output sample_t        dds_o      // Sawtooth, top phase byte
);

    logic   wr_en;
    logic   wr_phase;
    phase_t inc_q;      // Phase increment per clock
    phase_t phase_q;    // Accumulator

    assign wr_en    = sel_i && penable_i && pwrite_i;
    assign wr_phase = wr_en && (offset_i == REG_PHASE);

    //////////////////////////////////////////////////////////////////////
    // Increment register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i)
            inc_q <= '0;
        else if (wr_en && offset_i == REG_PHASE_INC)
            inc_q <= phase_t'(wdata_i);
    end

    //////////////////////////////////////////////////////////////////////
    // Phase accumulator
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i)
            phase_q <= '0;
        else if (wr_phase)
            phase_q <= phase_t'(wdata_i);  // Load replaces the add
        else
            phase_q <= phase_q + inc_q;    // Wraps modulo 2^32
    end

    // Straight from the accumulator, no output flop
    assign dds_o = sample_t'(phase_q[PHASE_W-1:PHASE_MSB_LO]);

    // Read back
    always_comb begin
        case (offset_i)
            REG_PHASE_INC: rdata_o = apb_data_t'(inc_q);
            REG_PHASE:     rdata_o = apb_data_t'(phase_q);  // Live value
            default:       rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/apb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_decode import r24_bus_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_i,

    input  wire logic      psel_i,
    input  wire apb_addr_t paddr_i,

    output logic           sel_ina_o,
    output logic           sel_inb_o,
    output logic           sel_outa_o,
    output logic           sel_outb_o,
    output logic           sel_ddsa_o,
    output logic           sel_ddsb_o,

    input  wire apb_data_t rdata_ina_i,
    input  wire apb_data_t rdata_inb_i,
    input  wire apb_data_t rdata_outa_i,
    input  wire apb_data_t rdata_outb_i,
    input  wire apb_data_t rdata_ddsa_i,
    input  wire apb_data_t rdata_ddsb_i,
    output apb_data_t      prdata_o
);

    region_t region;

    assign region = paddr_i[ADDR_W-1:OFFSET_W];  // Top nibble

    // Per-block selects, qualified by psel
    assign sel_ina_o  = psel_i && (region == REGION_INA);
    assign sel_inb_o  = psel_i && (region == REGION_INB);
    assign sel_outa_o = psel_i && (region == REGION_OUTA);
    assign sel_outb_o = psel_i && (region == REGION_OUTB);
    assign sel_ddsa_o = psel_i && (region == REGION_DDSA);
    assign sel_ddsb_o = psel_i && (region == REGION_DDSB);

    // AND-OR read mux, one-hot selects so at most one term is live
    // Unmapped regions have no select and read zero
    assign prdata_o = ({DATA_W{sel_ina_o}}  & rdata_ina_i)
                    | ({DATA_W{sel_inb_o}}  & rdata_inb_i)
                    | ({DATA_W{sel_outa_o}} & rdata_outa_i)
                    | ({DATA_W{sel_outb_o}} & rdata_outb_i)
                    | ({DATA_W{sel_ddsa_o}} & rdata_ddsa_i)
                    | ({DATA_W{sel_ddsb_o}} & rdata_ddsb_i);

    sel_onehot: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0({sel_ina_o, sel_inb_o, sel_outa_o, sel_outb_o, sel_ddsa_o, sel_ddsb_o}));

endmodule

`default_nettype wire

// ==== logic/r24bb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module r24bb_core import r24_bus_pkg::*, r24_dsp_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_i,

    // APB slave
    input  wire logic      psel_i,
    input  wire logic      penable_i,
    input  wire logic      pwrite_i,
    input  wire apb_addr_t paddr_i,
    input  wire apb_data_t pwdata_i,
    output apb_data_t      prdata_o,
    output logic           pready_o,
    output logic           pslverr_o,

    // Converter samples
    input  wire sample_t   adc_a_i,
    input  wire sample_t   adc_b_i,
    input  wire logic      adc_a_dor_i,
    input  wire logic      adc_b_dor_i,
    output sample_t        dac_a_o,
    output sample_t        dac_b_o,

    // Front-end controls
    output att_t           ina_att_o,
    output att_t           inb_att_o,
    output att_t           outa_att_o,
    output att_t           outb_att_o,
    output logic           ina_amp_en_o,
    output logic           inb_amp_en_o,
    output logic           outa_amp_en_o,
    output logic           outb_amp_en_o
);

    offset_t   offset;  // Shared by every block
    logic      sel_ina, sel_inb, sel_outa, sel_outb, sel_ddsa, sel_ddsb;
    apb_data_t rdata_ina, rdata_inb, rdata_outa, rdata_outb, rdata_ddsa, rdata_ddsb;
    sample_t   ina_data, inb_data, ddsa_data, ddsb_data;

    assign offset    = paddr_i[OFFSET_W-1:0];
    assign pready_o  = 1'b1;  // No wait states
    assign pslverr_o = 1'b0;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    apb_decode u_decode (
        .clk(clk), .rst_i(rst_i), .psel_i(psel_i), .paddr_i(paddr_i),
        .sel_ina_o(sel_ina), .sel_inb_o(sel_inb), .sel_outa_o(sel_outa),
        .sel_outb_o(sel_outb), .sel_ddsa_o(sel_ddsa), .sel_ddsb_o(sel_ddsb),
        .rdata_ina_i(rdata_ina), .rdata_inb_i(rdata_inb), .rdata_outa_i(rdata_outa),
        .rdata_outb_i(rdata_outb), .rdata_ddsa_i(rdata_ddsa), .rdata_ddsb_i(rdata_ddsb),
        .prdata_o(prdata_o)
    );

    //////////////////////////////////////////////////////////////////////
    // ADC input channels
    //////////////////////////////////////////////////////////////////////

    adc_channel ina (
        .clk(clk), .rst_i(rst_i), .sel_i(sel_ina), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .offset_i(offset), .wdata_i(pwdata_i), .rdata_o(rdata_ina),
        .sample_i(adc_a_i), .dor_i(adc_a_dor_i), .sample_o(ina_data),
        .att_o(ina_att_o), .amp_en_o(ina_amp_en_o)
    );

    adc_channel inb (
        .clk(clk), .rst_i(rst_i), .sel_i(sel_inb), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .offset_i(offset), .wdata_i(pwdata_i), .rdata_o(rdata_inb),
        .sample_i(adc_b_i), .dor_i(adc_b_dor_i), .sample_o(inb_data),
        .att_o(inb_att_o), .amp_en_o(inb_amp_en_o)
    );

    //////////////////////////////////////////////////////////////////////
    // DAC output channels
    //////////////////////////////////////////////////////////////////////

    dac_channel outa (
        .clk(clk), .rst_i(rst_i), .sel_i(sel_outa), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .offset_i(offset), .wdata_i(pwdata_i), .rdata_o(rdata_outa),
        .ina_i(ina_data), .inb_i(inb_data), .ddsa_i(ddsa_data), .ddsb_i(ddsb_data),
        .dac_o(dac_a_o), .att_o(outa_att_o), .amp_en_o(outa_amp_en_o)
    );

    dac_channel outb (
        .clk(clk), .rst_i(rst_i), .sel_i(sel_outb), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .offset_i(offset), .wdata_i(pwdata_i), .rdata_o(rdata_outb),
        .ina_i(ina_data), .inb_i(inb_data), .ddsa_i(ddsa_data), .ddsb_i(ddsb_data),
        .dac_o(dac_b_o), .att_o(outb_att_o), .amp_en_o(outb_amp_en_o)
    );

    //////////////////////////////////////////////////////////////////////
    // DDS generators
    //////////////////////////////////////////////////////////////////////

    dds_block ddsa (
        .clk(clk), .rst_i(rst_i), .sel_i(sel_ddsa), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .offset_i(offset), .wdata_i(pwdata_i), .rdata_o(rdata_ddsa),
        .dds_o(ddsa_data)
    );

    dds_block ddsb (
        .clk(clk), .rst_i(rst_i), .sel_i(sel_ddsb), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .offset_i(offset), .wdata_i(pwdata_i), .rdata_o(rdata_ddsb),
        .dds_o(ddsb_data)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the r24bb_core testbench with Verilator

if ! cd "$(dirname "$0")"; then
    echo "Cannot enter the project root"
    exit 1
fi

if ! verilator --binary --timing --assert -f sources.f \
        --top-module r24bb_core_tb -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vr24bb_core_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== sources.f ====
common/r24_bus_pkg.sv
common/r24_dsp_pkg.sv
logic/apb_decode.sv
adc/adc_channel.sv
dac/dac_channel.sv
dds/dds_block.sv
logic/r24bb_core.sv
verification/r24bb_core_tb.sv

// ==== verification/r24bb_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module r24bb_core_tb import r24_bus_pkg::*, r24_dsp_pkg::*; ();

    localparam int          READY_TIMEOUT = 16;         // Cycles allowed for pready
    localparam logic [15:0] LFSR_SEED     = 16'd63863;
    localparam logic [15:0] LFSR_TAPS     = 16'hB400;   // x^16 + x^14 + x^13 + x^11 + 1
    localparam int          RAMP_STEPS    = 12;

    typedef enum logic [2:0] {
        OP_WR,    // APB write
        OP_RD,    // APB read and compare
        OP_ADC,   // Drive samples and dor flags in data[17:16]
        OP_OUT,   // Settle then compare DAC outputs and front-end pins
        OP_RAMP   // DAC B steps by exp_val for data cycles
    } op_t;

    typedef struct {
        op_t       op;
        apb_addr_t addr;
        apb_data_t data;
        apb_data_t exp_val;
    } row_t;

    logic        clk;
    logic        rst_i;
    logic        psel_i, penable_i, pwrite_i;
    apb_addr_t   paddr_i;
    apb_data_t   pwdata_i;
    apb_data_t   prdata_o;
    logic        pready_o, pslverr_o;
    sample_t     adc_a_i, adc_b_i, dac_a_o, dac_b_o;
    logic        adc_a_dor_i, adc_b_dor_i;
    att_t        ina_att_o, inb_att_o, outa_att_o, outb_att_o;
    logic        ina_amp_en_o, inb_amp_en_o, outa_amp_en_o, outb_amp_en_o;
    logic [15:0] lfsr_state;
    row_t        table_q[$];   // Stimulus and expected values

    r24bb_core dut (
        .clk(clk), .rst_i(rst_i), .psel_i(psel_i), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o),
        .adc_a_i(adc_a_i), .adc_b_i(adc_b_i), .adc_a_dor_i(adc_a_dor_i),
        .adc_b_dor_i(adc_b_dor_i), .dac_a_o(dac_a_o), .dac_b_o(dac_b_o),
        .ina_att_o(ina_att_o), .inb_att_o(inb_att_o), .outa_att_o(outa_att_o),
        .outb_att_o(outb_att_o), .ina_amp_en_o(ina_amp_en_o), .inb_amp_en_o(inb_amp_en_o),
        .outa_amp_en_o(outa_amp_en_o), .outb_amp_en_o(outb_amp_en_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;   // 40 ns period

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ LFSR_TAPS;
        else
            return s >> 1;
    endfunction

    // One LFSR step per bit
    function automatic logic [7:0] random_byte();
        logic [7:0] val;
        val = 8'h00;
        for (int n = 0; n < 8; n++) begin
            val        = {lfsr_state[0], val[7:1]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return val;
    endfunction

    function automatic apb_addr_t reg_addr(input region_t region, input offset_t offset);
        return {region, offset};
    endfunction

    // Pin image of {outb, outa, inb, ina} CTRL fields then DAC B and DAC A
    function automatic apb_data_t out_exp(input logic [2:0] ina, input logic [2:0] inb,
                                          input logic [2:0] outa, input logic [2:0] outb,
                                          input logic [7:0] dac_a, input logic [7:0] dac_b);
        return {4'h0, outb, outa, inb, ina, dac_b, dac_a};
    endfunction

    function automatic apb_data_t outputs_now();
        return {4'h0, outb_amp_en_o, outb_att_o, outa_amp_en_o, outa_att_o,
                inb_amp_en_o, inb_att_o, ina_amp_en_o, ina_att_o, dac_b_o, dac_a_o};
    endfunction

    task automatic check_value(input apb_data_t actual, input apb_data_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // APB master
    //////////////////////////////////////////////////////////////////////

    task automatic apb_access(input logic is_write, input apb_addr_t addr,
                              input apb_data_t wdata, output apb_data_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);                // Setup phase
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= is_write;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk);                // Access phase
        penable_i <= 1'b1;
        @(negedge clk);
        while (!pready_o) begin
            if (waited >= READY_TIMEOUT) begin
                $display("APB slave gave no pready within %0d cycles at address 0x%04h",
                         READY_TIMEOUT, addr);
                $display("Test failed");
                $fatal(1, "APB transfer timed out");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        rdata = prdata_o;              // Sampled mid-cycle where it is stable
        check_value({31'h0, pslverr_o}, 32'h0, "pslverr during transfer");
        @(posedge clk);                // Transfer completes at this edge
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
        apb_data_t unused_rdata;
        apb_access(1'b1, addr, wdata, unused_rdata);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
        apb_access(1'b0, addr, 32'h0, rdata);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Table
    //////////////////////////////////////////////////////////////////////

    function automatic void add_row(input op_t op, input apb_addr_t addr,
                                    input apb_data_t data, input apb_data_t exp_val);
        row_t row;
        row.op      = op;
        row.addr    = addr;
        row.data    = data;
        row.exp_val = exp_val;
        table_q.push_back(row);
    endfunction

    task automatic build_table();
        logic [7:0] a;
        logic [7:0] b;
        apb_data_t  dds_inc;
        lfsr_state = LFSR_SEED;
        a          = 8'h00;
        b          = 8'h00;
        dds_inc    = apb_data_t'(1) << PHASE_MSB_LO;   // One output step per cycle
        // Reset state
        add_row(OP_OUT, 16'h0, 32'h0, out_exp(3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 8'h00));
        add_row(OP_RD, reg_addr(REGION_INA, REG_CTRL), 32'h0, 32'h0);
        add_row(OP_RD, reg_addr(REGION_INB, REG_CTRL), 32'h0, 32'h0);
        add_row(OP_RD, reg_addr(REGION_OUTA, REG_CTRL), 32'h0, 32'h0);
        add_row(OP_RD, reg_addr(REGION_OUTB, REG_CTRL), 32'h0, 32'h0);
        add_row(OP_RD, reg_addr(REGION_OUTA, REG_SRC), 32'h0, apb_data_t'(SRC_INA));
        add_row(OP_RD, reg_addr(REGION_DDSA, REG_PHASE_INC), 32'h0, 32'h0);
        // Register readback with att in [1:0] and amp_en in [2]
        add_row(OP_WR, reg_addr(REGION_INA, REG_CTRL), 32'h5, 32'h0);
        add_row(OP_RD, reg_addr(REGION_INA, REG_CTRL), 32'h0, 32'h5);
        add_row(OP_WR, reg_addr(REGION_INB, REG_CTRL), 32'h2, 32'h0);
        add_row(OP_RD, reg_addr(REGION_INB, REG_CTRL), 32'h0, 32'h2);
        add_row(OP_WR, reg_addr(REGION_OUTA, REG_CTRL), 32'h7, 32'h0);
        add_row(OP_RD, reg_addr(REGION_OUTA, REG_CTRL), 32'h0, 32'h7);
        add_row(OP_WR, reg_addr(REGION_OUTB, REG_CTRL), 32'h3, 32'h0);
        add_row(OP_RD, reg_addr(REGION_OUTB, REG_CTRL), 32'h0, 32'h3);
        add_row(OP_WR, reg_addr(REGION_OUTA, REG_SRC), apb_data_t'(SRC_CONST), 32'h0);
        add_row(OP_RD, reg_addr(REGION_OUTA, REG_SRC), 32'h0, apb_data_t'(SRC_CONST));
        add_row(OP_WR, reg_addr(REGION_OUTA, REG_SRC), 32'h7, 32'h0);   // Illegal code
        add_row(OP_RD, reg_addr(REGION_OUTA, REG_SRC), 32'h0, apb_data_t'(SRC_CONST));
        add_row(OP_WR, reg_addr(REGION_OUTA, REG_CONST), 32'hA5, 32'h0);
        add_row(OP_RD, reg_addr(REGION_OUTA, REG_CONST), 32'h0, 32'hA5);
        add_row(OP_WR, reg_addr(REGION_OUTB, REG_CONST), 32'h3C, 32'h0);
        add_row(OP_RD, reg_addr(REGION_OUTB, REG_CONST), 32'h0, 32'h3C);
        add_row(OP_WR, reg_addr(REGION_DDSA, REG_PHASE_INC), 32'h12345678, 32'h0);
        add_row(OP_RD, reg_addr(REGION_DDSA, REG_PHASE_INC), 32'h0, 32'h12345678);
        add_row(OP_RD, reg_addr(4'd4, REG_CTRL), 32'h0, 32'h0);        // Unmapped regions
        add_row(OP_RD, reg_addr(4'd7, REG_CTRL), 32'h0, 32'h0);
        add_row(OP_RD, reg_addr(REGION_OUTA, 12'h00C), 32'h0, 32'h0);  // Unused offset
        add_row(OP_OUT, 16'h0, 32'h0, out_exp(3'd5, 3'd2, 3'd7, 3'd3, 8'hA5, 8'h00));
        // ADC to DAC pass-through
        add_row(OP_WR, reg_addr(REGION_OUTA, REG_SRC), apb_data_t'(SRC_INA), 32'h0);
        add_row(OP_WR, reg_addr(REGION_OUTB, REG_SRC), apb_data_t'(SRC_INB), 32'h0);
        add_row(OP_RD, reg_addr(REGION_OUTB, REG_SRC), 32'h0, apb_data_t'(SRC_INB));
        for (int k = 0; k < 4; k++) begin
            a = random_byte();
            b = random_byte();
            add_row(OP_ADC, 16'h0, {16'h0, b, a}, 32'h0);
            add_row(OP_OUT, 16'h0, 32'h0, out_exp(3'd5, 3'd2, 3'd7, 3'd3, a, b));
            add_row(OP_RD, reg_addr(REGION_INA, REG_SAMPLE), 32'h0, {{24{a[7]}}, a});
            add_row(OP_RD, reg_addr(REGION_INB, REG_SAMPLE), 32'h0, {{24{b[7]}}, b});
        end
        // Overrange pulse on ADC B only
        add_row(OP_ADC, 16'h0, {14'h0, 1'b1, 1'b0, b, a}, 32'h0);
        add_row(OP_ADC, 16'h0, {16'h0, b, a}, 32'h0);
        add_row(OP_RD, reg_addr(REGION_INB, REG_STATUS), 32'h0, 32'h1);
        add_row(OP_RD, reg_addr(REGION_INA, REG_STATUS), 32'h0, 32'h0);
        add_row(OP_WR, reg_addr(REGION_INB, REG_STATUS), 32'h1, 32'h0);
        add_row(OP_RD, reg_addr(REGION_INB, REG_STATUS), 32'h0, 32'h0);
        // DDS hold then ramp
        add_row(OP_WR, reg_addr(REGION_DDSA, REG_PHASE_INC), 32'h0, 32'h0);
        add_row(OP_WR, reg_addr(REGION_DDSA, REG_PHASE), 32'h5A000000, 32'h0);
        add_row(OP_WR, reg_addr(REGION_OUTA, REG_SRC), apb_data_t'(SRC_DDSA), 32'h0);
        add_row(OP_OUT, 16'h0, 32'h0, out_exp(3'd5, 3'd2, 3'd7, 3'd3, 8'h5A, b));
        add_row(OP_RD, reg_addr(REGION_DDSA, REG_PHASE), 32'h0, 32'h5A000000);
        add_row(OP_WR, reg_addr(REGION_DDSB, REG_PHASE_INC), dds_inc, 32'h0);
        add_row(OP_RD, reg_addr(REGION_DDSB, REG_PHASE_INC), 32'h0, dds_inc);
        add_row(OP_WR, reg_addr(REGION_OUTB, REG_SRC), apb_data_t'(SRC_DDSB), 32'h0);
        add_row(OP_RAMP, 16'h0, RAMP_STEPS, 32'h1);
    endtask

    task automatic apply_row(input row_t row, input int idx);
        apb_data_t  rdata;
        logic [7:0] prev;
        logic [7:0] cur;
        logic [7:0] step_exp;
        case (row.op)
            OP_WR: apb_write(row.addr, row.data);
            OP_RD: begin
                apb_read(row.addr, rdata);
                check_value(rdata, row.exp_val, $sformatf("row %0d read 0x%04h", idx, row.addr));
            end
            OP_ADC: begin
                @(posedge clk);
                adc_a_i     <= sample_t'(row.data[7:0]);
                adc_b_i     <= sample_t'(row.data[15:8]);
                adc_a_dor_i <= row.data[16];
                adc_b_dor_i <= row.data[17];
            end
            OP_OUT: begin
                repeat (3) @(posedge clk);   // ADC to DAC is two cycles
                @(negedge clk);
                check_value(outputs_now(), row.exp_val, $sformatf("row %0d outputs", idx));
            end
            OP_RAMP: begin
                repeat (3) @(posedge clk);   // New source reaches the pin
                @(negedge clk);
                prev = dac_b_o;
                for (int n = 0; n < int'(row.data); n++) begin
                    @(negedge clk);
                    cur      = dac_b_o;
                    step_exp = prev + row.exp_val[7:0];   // Wraps mod 256
                    check_value({24'h0, cur}, {24'h0, step_exp},
                                $sformatf("row %0d DDS step %0d", idx, n));
                    prev = cur;
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        rst_i       <= 1'b1;
        psel_i      <= 1'b0;
        penable_i   <= 1'b0;
        pwrite_i    <= 1'b0;
        paddr_i     <= '0;
        pwdata_i    <= '0;
        adc_a_i     <= '0;
        adc_b_i     <= '0;
        adc_a_dor_i <= 1'b0;
        adc_b_dor_i <= 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        for (int i = 0; i < table_q.size(); i++)
            apply_row(table_q[i], i);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
